// ==== filelist.f ====
ahb_apb_pkg.sv
ahb_req_capture.sv
apb_xfer_fsm.sv
apb_data_path.sv
ahb_apb_bridge.sv
tb_ahb_apb_bridge_assert.sv
tb_ahb_apb_bridge.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert \
  --top-module tb_ahb_apb_bridge \
  -f filelist.f \
  --Mdir obj_dir -o sim_bridge

status=0
./obj_dir/sim_bridge > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Verification passed" sim.log; then
  echo "Simulation PASS"
  exit 0
else
  echo "Simulation FAIL (exit status ${status})"
  exit 1
fi

// ==== tb_ahb_apb_bridge.sv ====
/*
 * Testbench for the AHB to APB bridge.
 * An AHB master issues random single transfers, an APB slave memory
 * model answers with random wait states and PSLVERR above bit 15,
 * and a shadow-memory reference predicts data, strobes and errors.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_ahb_apb_bridge;

  import ahb_apb_pkg::*;

  localparam int num_ops   = 150;
  localparam int max_wait  = 200; // HCLK cycles per transfer

  logic          HCLK;
  logic          HRESETn;
  logic          hsel;
  logic [15:0]   haddr;
  htrans_t       htrans;
  hsize_t        hsize;
  logic [3:0]    hprot;
  logic          hwrite;
  logic [31:0]   hwdata;
  wire           hreadyout;
  wire  [31:0]   hrdata;
  wire           hresp;
  logic          pclken;
  wire  [31:0]   prdata;
  logic          pready;
  wire           pslverr;
  wire  [15:0]   paddr;
  wire           penable;
  wire           pwrite;
  wire  [3:0]    pstrb;
  wire  [2:0]    pprot;
  wire  [31:0]   pwdata;
  wire           psel;
  wire           apbactive;

  integer        seed;
  logic [31:0]   apb_mem [0:255];  // APB slave storage
  logic [31:0]   shadow  [0:255];  // Reference copy
  integer        wait_cnt;
  logic [15:0]   obs_addr;         // Seen in the APB setup phase
  logic [3:0]    obs_strb;
  logic [2:0]    obs_prot;
  logic          obs_write;
  logic [31:0]   obs_wdata;        // Seen at write completion

  ahb_apb_bridge #(
    .addr_width     (16),
    .register_rdata (1),
    .register_wdata (1)
  ) UUT (
    .HCLK      (HCLK),      .HRESETn   (HRESETn),
    .hsel      (hsel),      .haddr     (haddr),
    .htrans    (htrans),    .hsize     (hsize),
    .hprot     (hprot),     .hwrite    (hwrite),
    .hready    (hreadyout), .hwdata    (hwdata), // HREADY loops back from the only slave
    .hreadyout (hreadyout), .hrdata    (hrdata),
    .hresp     (hresp),     .pclken    (pclken),
    .prdata    (prdata),    .pready    (pready),
    .pslverr   (pslverr),   .paddr     (paddr),
    .penable   (penable),   .pwrite    (pwrite),
    .pstrb     (pstrb),     .pprot     (pprot),
    .pwdata    (pwdata),    .psel      (psel),
    .apbactive (apbactive)
  );

  initial
  begin
    HCLK = 1'b0;
    forever #50 HCLK = ~HCLK;
  end

  // ------------------------------------------------------------------------
  // APB slave model
  // ------------------------------------------------------------------------
  assign prdata  = apb_mem[paddr[9:2]];
  assign pslverr = paddr[15]; // Upper half of the map is faulty

  initial
  begin
    forever
    begin
      @(negedge HCLK);
      pclken = ($random(seed) & 3) != 0; // Mostly high
      if (psel && penable)
      begin
        pready = (wait_cnt == 0);
        if (wait_cnt != 0)
          wait_cnt = wait_cnt - 1;
      end
      else
      begin
        pready   = 1'b0;
        wait_cnt = $random(seed) & 3; // 0 to 3 wait states
      end
      #5;
      if (psel && !penable)
      begin
        obs_addr  = paddr;
        obs_strb  = pstrb;
        obs_prot  = pprot;
        obs_write = pwrite;
      end
      // This cycle completes at the next rising edge
      if (psel && penable && pready && pclken && pwrite)
      begin
        obs_wdata = pwdata;
        if (!paddr[15])
          for (int b = 0; b < 4; b++)
            if (pstrb[b])
              apb_mem[paddr[9:2]][8*b +: 8] = pwdata[8*b +: 8];
      end
    end
  end

  // ------------------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------------------
  function automatic logic [3:0] exp_strb(input logic wr, input logic [2:0] size,
                                          input logic [1:0] lsb);
    logic [3:0] s;
    if (!wr)
      s = 4'b0000;
    else if (size == 3'd0)
      s = 4'b0001 << lsb;
    else if (size == 3'd1)
      s = lsb[1] ? 4'b1100 : 4'b0011;
    else
      s = 4'b1111;
    return s;
  endfunction

  // Merges a write into the shadow and returns the word after the access
  function automatic logic [31:0] ref_access(input logic wr, input logic [15:0] addr,
                                             input logic [2:0] size,
                                             input logic [31:0] wdata);
    logic [31:0] word;
    logic [3:0]  s;
    word = shadow[addr[9:2]];
    s    = exp_strb(wr, size, addr[1:0]);
    if (wr && !addr[15])
    begin
      for (int b = 0; b < 4; b++)
        if (s[b])
          word[8*b +: 8] = wdata[8*b +: 8];
      shadow[addr[9:2]] = word;
    end
    return word;
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string msg);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
      $display("Verification failed");
      $fatal(1, "Mismatch");
    end
  endtask

  // ------------------------------------------------------------------------
  // AHB master
  // ------------------------------------------------------------------------
  task automatic ahb_transfer(input logic wr, input logic [15:0] addr,
                              input logic [2:0] size, input logic [3:0] prot,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic resp, output logic err_first);
    int cycles;
    cycles    = 0;
    err_first = 1'b0;
    @(negedge HCLK);                 // Address phase
    hsel   = 1'b1;
    htrans = htrans_nonseq;
    haddr  = addr;
    hsize  = hsize_t'(size);
    hprot  = prot;
    hwrite = wr;
    #10;
    check_value(32'(apbactive), 1, "apbactive in address phase");
    @(negedge HCLK);                 // Data phase
    hsel   = 1'b0;
    htrans = htrans_idle;
    hwdata = wdata;
    forever
    begin
      #10;
      if (hresp && !hreadyout)
        err_first = 1'b1;
      if (hreadyout)
        break;
      cycles++;
      if (cycles > max_wait)
      begin
        $display("Timeout: hreadyout stayed low in a data phase at %0t ns", $time);
        $display("Verification failed");
        $fatal(1, "Timeout");
      end
      @(negedge HCLK);
    end
    rdata = hrdata;
    resp  = hresp;
  endtask

  // ------------------------------------------------------------------------
  // Main sequence and compare
  // ------------------------------------------------------------------------
  initial
  begin
    logic        wr;
    logic        resp;
    logic        err_first;
    logic [15:0] addr;
    logic [2:0]  size;
    logic [3:0]  prot;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic [31:0] exp;

    seed     = 63721;
    HRESETn  = 1'b0;
    hsel     = 1'b0;
    haddr    = '0;
    htrans   = htrans_idle;
    hsize    = hsize_word;
    hprot    = 4'h0;
    hwrite   = 1'b0;
    hwdata   = '0;
    pclken   = 1'b0;
    pready   = 1'b0;
    wait_cnt = 0;
    for (int i = 0; i < 256; i++)
    begin
      apb_mem[i] = 32'h5A00_0000 ^ (i * 32'h0101_0101); // Depends on every index bit
      shadow[i]  = 32'h5A00_0000 ^ (i * 32'h0101_0101);
    end
    repeat (3) @(negedge HCLK);
    HRESETn = 1'b1;

    // Idle after reset
    @(negedge HCLK);
    #10;
    check_value(32'(psel), 0, "psel after reset");
    check_value(32'(penable), 0, "penable after reset");
    check_value(32'(hresp), 0, "hresp after reset");
    check_value(32'(apbactive), 0, "apbactive after reset");
    check_value(32'(hreadyout), 1, "hreadyout after reset");

    for (int n = 0; n < num_ops; n++)
    begin
      wr   = 1'($random(seed));
      size = wr ? 3'(($random(seed) % 3 + 3) % 3) : 3'd2; // Reads are word sized
      addr = {10'h000, 4'($random(seed)), 2'b00};          // 16 words so writes merge often
      if (size == 3'd0)
        addr[1:0] = 2'($random(seed));
      else if (size == 3'd1)
        addr[1] = 1'($random(seed));
      if (($random(seed) & 7) == 0)
        addr[15] = 1'b1;               // Faulty region
      prot  = 4'($random(seed));
      wdata = $random(seed);
      exp   = ref_access(wr, addr, size, wdata);

      ahb_transfer(wr, addr, size, prot, wdata, rdata, resp, err_first);

      check_value(32'(resp), 32'(addr[15]), "hresp at end of transfer");
      if (addr[15])
        check_value(32'(err_first), 1, "first ERROR cycle with hreadyout low");
      else if (!wr)
        check_value(rdata, exp, "read data");
      check_value(32'(obs_addr), 32'({addr[15:2], 2'b00}), "paddr");
      check_value(32'(obs_write), 32'(wr), "pwrite");
      check_value(32'(obs_strb), 32'(exp_strb(wr, size, addr[1:0])), "pstrb");
      check_value(32'(obs_prot), 32'({~prot[0], 1'b0, prot[1]}), "pprot");
      if (wr)
        check_value(obs_wdata, wdata, "pwdata");
    end

    // Final read back of every touched word
    for (int w = 0; w < 16; w++)
    begin
      addr = 16'(w * 4);
      exp  = ref_access(1'b0, addr, 3'd2, 32'h0);
      ahb_transfer(1'b0, addr, 3'd2, 4'h1, 32'h0, rdata, resp, err_first);
      check_value(32'(resp), 0, "hresp on read back");
      check_value(rdata, exp, "read back data");
    end

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_ahb_apb_bridge_assert.sv ====
/*
 * Protocol assertions for the AHB to APB bridge.
 * Bound into every ahb_apb_bridge instance; checks APB select and
 * enable ordering, the two-cycle ERROR response and request stability.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_ahb_apb_bridge_assert (
  input wire        HCLK,
  input wire        HRESETn,
  input wire        psel,
  input wire        penable,
  input wire        apbactive,
  input wire        hresp,
  input wire        hreadyout,
  input wire        pready,
  input wire        pclken,
  input wire        pwrite,
  input wire [3:0]  pstrb,
  input wire [15:0] paddr
);

  logic apb_complete;

  assign apb_complete = psel & penable & pready & pclken; // Last access cycle

  a_enable_sel: assert property (@(posedge HCLK) disable iff (!HRESETn)
    penable |-> psel) else $error("penable without psel");

  a_sel_active: assert property (@(posedge HCLK) disable iff (!HRESETn)
    psel |-> apbactive) else $error("psel without apbactive");

  a_two_cycle_err: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (hresp && !hreadyout) |=> (hresp && hreadyout)) else $error("ERROR response too short");

  a_req_stable: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (psel && !apb_complete) |=> ($stable(paddr) && $stable(pwrite) && $stable(pstrb)))
    else $error("APB request changed mid transfer");

endmodule

bind ahb_apb_bridge tb_ahb_apb_bridge_assert u_assert (
  .HCLK      (HCLK),
  .HRESETn   (HRESETn),
  .psel      (psel),
  .penable   (penable),
  .apbactive (apbactive),
  .hresp     (hresp),
  .hreadyout (hreadyout),
  .pready    (pready),
  .pclken    (pclken),
  .pwrite    (pwrite),
  .pstrb     (pstrb),
  .paddr     (paddr)
);

`default_nettype wire

// ==== ahb_apb_bridge.sv ====
/*
 * AHB to APB bridge, top level.
 * PCLK must be HCLK divided down, marked by the PCLKEN enable. Tie
 * PCLKEN high when both run at the same rate. register_rdata and
 * register_wdata add a sample stage on the read or write data.
 */
`timescale 1ns/1ps
`default_nettype none

module ahb_apb_bridge #(
  parameter int unsigned addr_width     = ahb_apb_pkg::addr_width_default,
  parameter int unsigned register_rdata = 1,
  parameter int unsigned register_wdata = 0
) (
  input  wire                                HCLK,
  input  wire                                HRESETn,
  // ------------------------------------------------------------------------
  // AHB slave side
  // ------------------------------------------------------------------------
  input  wire                                hsel,
  input  wire [addr_width-1:0]               haddr,
  input  wire ahb_apb_pkg::htrans_t          htrans,
  input  wire ahb_apb_pkg::hsize_t           hsize,
  input  wire [3:0]                          hprot,     // Bits 3:2 not mapped
  input  wire                                hwrite,
  input  wire                                hready,
  input  wire [ahb_apb_pkg::data_width-1:0]  hwdata,
  output logic                               hreadyout,
  output logic [ahb_apb_pkg::data_width-1:0] hrdata,
  output logic                               hresp,     // 0 OKAY, 1 ERROR
  // ------------------------------------------------------------------------
  // APB master side
  // ------------------------------------------------------------------------
  input  wire                                pclken,
  input  wire [ahb_apb_pkg::data_width-1:0]  prdata,
  input  wire                                pready,
  input  wire                                pslverr,
  output logic [addr_width-1:0]              paddr,
  output logic                               penable,
  output logic                               pwrite,
  output logic [ahb_apb_pkg::strb_width-1:0] pstrb,
  output logic [2:0]                         pprot,
  output logic [ahb_apb_pkg::data_width-1:0] pwdata,
  output logic                               psel,
  output logic                               apbactive  // For APB clock gating
);

  wire xfer_start;
  wire wdata_defer;
  wire apb_done;

  ahb_req_capture #(
    .addr_width     (addr_width),
    .register_wdata (register_wdata)
  ) u_req (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .hsel        (hsel),
    .htrans      (htrans),
    .hready      (hready),
    .haddr       (haddr),
    .hsize       (hsize),
    .hprot       (hprot),
    .hwrite      (hwrite),
    .xfer_start  (xfer_start),
    .wdata_defer (wdata_defer),
    .paddr       (paddr),
    .pwrite      (pwrite),
    .pstrb       (pstrb),
    .pprot       (pprot)
  );

  apb_xfer_fsm #(
    .register_rdata (register_rdata)
  ) u_fsm (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .pclken      (pclken),
    .xfer_start  (xfer_start),
    .wdata_defer (wdata_defer),
    .hsel        (hsel),
    .htrans      (htrans),
    .pready      (pready),
    .pslverr     (pslverr),
    .psel        (psel),
    .penable     (penable),
    .hreadyout   (hreadyout),
    .hresp       (hresp),
    .apb_done    (apb_done),
    .apbactive   (apbactive)
  );

  apb_data_path #(
    .register_rdata (register_rdata),
    .register_wdata (register_wdata)
  ) u_data (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .pclken      (pclken),
    .wdata_defer (wdata_defer),
    .apb_done    (apb_done),
    .hwdata      (hwdata),
    .prdata      (prdata),
    .pwdata      (pwdata),
    .hrdata      (hrdata)
  );

endmodule

`default_nettype wire

// ==== apb_data_path.sv ====
/*
 * Data path of the bridge.
 * A single sample register serves either as the HWDATA holding
 * register or as the PRDATA capture register, each as enabled by the
 * parameters. Without it, data passes straight between the buses.
 */
`timescale 1ns/1ps
`default_nettype none

module apb_data_path #(
  parameter int unsigned register_rdata = 1,
  parameter int unsigned register_wdata = 0
) (
  input  wire                                HCLK,
  input  wire                                HRESETn,
  input  wire                                pclken,
  input  wire                                wdata_defer, // Write address phase, data follows
  input  wire                                apb_done,
  input  wire [ahb_apb_pkg::data_width-1:0]  hwdata,
  input  wire [ahb_apb_pkg::data_width-1:0]  prdata,
  output logic [ahb_apb_pkg::data_width-1:0] pwdata,
  output logic [ahb_apb_pkg::data_width-1:0] hrdata
);

  import ahb_apb_pkg::*;

  localparam bit reg_rdata = (register_rdata != 0);
  localparam bit reg_wdata = (register_wdata != 0);

  logic                  sample_wdata_q; // HWDATA valid, waiting for PCLKEN
  logic [data_width-1:0] rwdata_q;

  // Set after the write address phase, cleared on the next PCLKEN edge
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      sample_wdata_q <= 1'b0;
    else if (wdata_defer)
      sample_wdata_q <= 1'b1;
    else if (pclken)
      sample_wdata_q <= 1'b0;
  end

  // Shared sample register
  always_ff @(posedge HCLK)
  begin
    if (reg_wdata & sample_wdata_q & pclken)
      rwdata_q <= hwdata;
    else if (reg_rdata & apb_done)
      rwdata_q <= prdata;  // Held for the ENDOK cycle
  end

  assign pwdata = reg_wdata ? rwdata_q : hwdata;
  assign hrdata = reg_rdata ? rwdata_q : prdata;

endmodule

`default_nettype wire

// ==== apb_xfer_fsm.sv ====
/*
 * APB transfer sequencer for the bridge.
 * Steps each captured AHB transfer through the APB setup and access
 * phases on PCLKEN edges, holds the access phase while PREADY is low,
 * and drives the AHB ready and the OKAY or two-cycle ERROR response.
 */
`timescale 1ns/1ps
`default_nettype none

module apb_xfer_fsm #(
  parameter int unsigned register_rdata = 1
) (
  input  wire                       HCLK,
  input  wire                       HRESETn,
  input  wire                       pclken,      // APB clock enable
  input  wire                       xfer_start,
  input  wire                       wdata_defer,
  input  wire                       hsel,
  input  wire ahb_apb_pkg::htrans_t htrans,
  input  wire                       pready,
  input  wire                       pslverr,
  output logic                      psel,
  output logic                      penable,
  output logic                      hreadyout,
  output logic                      hresp,
  output logic                      apb_done,    // Access phase completes this cycle
  output logic                      apbactive    // Clock gating hint
);

  import ahb_apb_pkg::*;

  localparam bit reg_rdata = (register_rdata != 0);

  bridge_state_t state_q;
  bridge_state_t state_d;
  bridge_state_t start_state; // Where a new request leads from a free state
  logic          htrans_act;

  // ------------------------------------------------------------------------
  // Next state
  // ------------------------------------------------------------------------
  always_comb
  begin
    // Setup may follow at once unless write data still has to be sampled
    if (xfer_start & pclken & ~wdata_defer)
      start_state = st_apb_trnf;
    else if (xfer_start)
      start_state = st_apb_wait;
    else
      start_state = st_idle;

    case (state_q)
      st_idle,
      st_apb_endok,
      st_apb_err2  : state_d = start_state;
      st_apb_wait  : state_d = pclken ? st_apb_trnf : st_apb_wait;
      st_apb_trnf  : state_d = pclken ? st_apb_trnf2 : st_apb_trnf; // Setup lasts one PCLK
      st_apb_trnf2 :
      begin
        if (pready & pclken)
        begin
          if (pslverr)
            state_d = st_apb_err1;   // Two-cycle ERROR on AHB
          else if (reg_rdata)
            state_d = st_apb_endok;  // Give HRDATA a cycle to settle in the register
          else
            state_d = start_state;   // HREADYOUT already high, next may start
        end
        else
          state_d = st_apb_trnf2;    // Wait states
      end
      st_apb_err1  : state_d = st_apb_err2;
      default      : state_d = st_idle;
    endcase
  end

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      state_q <= st_idle;
    else
      state_q <= state_d;
  end

  // ------------------------------------------------------------------------
  // Output decode
  // ------------------------------------------------------------------------
  assign psel     = (state_q == st_apb_trnf) || (state_q == st_apb_trnf2);
  assign penable  = (state_q == st_apb_trnf2);
  assign hresp    = (state_q == st_apb_err1) || (state_q == st_apb_err2);
  assign apb_done = (state_q == st_apb_trnf2) & pready & pclken;

  always_comb
  begin
    case (state_q)
      st_idle      : hreadyout = 1'b1;
      st_apb_wait  : hreadyout = 1'b0;
      st_apb_trnf  : hreadyout = 1'b0;
      // Unregistered read data finishes in the completing access cycle
      st_apb_trnf2 : hreadyout = ~reg_rdata & pready & ~pslverr & pclken;
      st_apb_endok : hreadyout = 1'b1;
      st_apb_err1  : hreadyout = 1'b0; // ERROR first cycle stalls the master
      st_apb_err2  : hreadyout = 1'b1;
      default      : hreadyout = 1'b1;
    endcase
  end

  // Raised from the address phase on, so APB clocks can be woken early
  assign htrans_act = (htrans == htrans_nonseq) || (htrans == htrans_seq);
  assign apbactive  = (hsel & htrans_act) | (state_q != st_idle);

endmodule

`default_nettype wire

// ==== ahb_req_capture.sv ====
/*
 * AHB request capture for the bridge.
 * Detects the end of a selected AHB address phase and samples the
 * word address, direction, byte strobes and protection for the APB
 * side. Also flags writes whose data must be registered first.
 */
`timescale 1ns/1ps
`default_nettype none

module ahb_req_capture #(
  parameter int unsigned addr_width     = ahb_apb_pkg::addr_width_default,
  parameter int unsigned register_wdata = 0
) (
  input  wire                                 HCLK,
  input  wire                                 HRESETn,
  input  wire                                 hsel,
  input  wire ahb_apb_pkg::htrans_t           htrans,
  input  wire                                 hready,
  input  wire [addr_width-1:0]                haddr,
  input  wire ahb_apb_pkg::hsize_t            hsize,
  input  wire [3:0]                           hprot,
  input  wire                                 hwrite,
  output logic                                xfer_start,  // End of selected address phase
  output logic                                wdata_defer, // Write with registered HWDATA
  output logic [addr_width-1:0]               paddr,
  output logic                                pwrite,
  output logic [ahb_apb_pkg::strb_width-1:0]  pstrb,
  output logic [2:0]                          pprot
);

  import ahb_apb_pkg::*;

  localparam bit reg_wdata = (register_wdata != 0);

  logic [addr_width-3:0] addr_q;  // Word address only
  logic                  write_q;
  logic [strb_width-1:0] strb_q;
  logic [strb_width-1:0] strb_d;
  logic [1:0]            prot_q;  // {instruction, privileged}
  logic                  htrans_act;

  // ------------------------------------------------------------------------
  // Start condition
  // ------------------------------------------------------------------------
  assign htrans_act  = (htrans == htrans_nonseq) || (htrans == htrans_seq);
  assign xfer_start  = hsel & htrans_act & hready;
  assign wdata_defer = xfer_start & hwrite & reg_wdata; // Data arrives one cycle later

  // Byte lane decode that leaves reads without strobes
  always_comb
  begin
    case (hsize)
      hsize_byte : strb_d = 4'b0001 << haddr[1:0];
      hsize_half : strb_d = haddr[1] ? 4'b1100 : 4'b0011; // Upper or lower half
      default    : strb_d = 4'b1111;                      // Word
    endcase
    if (!hwrite)
      strb_d = '0;
  end

  // ------------------------------------------------------------------------
  // Request registers
  // ------------------------------------------------------------------------
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      addr_q  <= '0;
      write_q <= 1'b0;
      strb_q  <= '0;
      prot_q  <= 2'b00;
    end
    else if (xfer_start)
    begin
      addr_q  <= haddr[addr_width-1:2];
      write_q <= hwrite;
      strb_q  <= strb_d;
      prot_q  <= {~hprot[0], hprot[1]}; // Opcode fetch -> instruction, privileged
    end
  end

  assign paddr  = {addr_q, 2'b00}; // Always word aligned on APB
  assign pwrite = write_q;
  assign pstrb  = strb_q;
  assign pprot  = {prot_q[1], 1'b0, prot_q[0]}; // Secure access only

endmodule

`default_nettype wire

// ==== ahb_apb_pkg.sv ====
/*
 * Shared definitions for the AHB to APB bridge.
 * Holds the bus widths, the bridge state encoding and the AHB
 * transfer type and size codes. Modules refer to it by scoped names
 * in their port lists and import it inside their bodies.
 */
`default_nettype none

package ahb_apb_pkg;

  localparam int unsigned addr_width_default = 16; // 64KB APB space
  localparam int unsigned data_width         = 32;
  localparam int unsigned strb_width         = data_width / 8; // One strobe per byte lane

  // Bridge FSM encoding where 3'b111 is never entered
  typedef enum logic [2:0] {
    st_idle      = 3'd0, // Waiting for an AHB transfer
    st_apb_wait  = 3'd1, // Transfer taken, waiting for a PCLKEN edge
    st_apb_trnf  = 3'd2, // APB setup phase
    st_apb_trnf2 = 3'd3, // APB access phase
    st_apb_endok = 3'd4, // OKAY ending cycle with registered read data
    st_apb_err1  = 3'd5, // First ERROR cycle
    st_apb_err2  = 3'd6  // Second ERROR cycle
  } bridge_state_t;

  typedef enum logic [1:0] {
    htrans_idle   = 2'b00,
    htrans_busy   = 2'b01,
    htrans_nonseq = 2'b10,
    htrans_seq    = 2'b11
  } htrans_t;

  typedef enum logic [2:0] {
    hsize_byte = 3'b000,
    hsize_half = 3'b001,
    hsize_word = 3'b010
  } hsize_t;

endpackage

`default_nettype wire
